/* flist.f */
+incdir+design
+incdir+tests
design/udp_tx_pkg.sv
design/udp_start_capture.sv
design/ip_checksum.sv
design/crc32_d8.sv
design/frame_serializer.sv
design/udp_tx.sv
tests/udp_tx_tb.sv

/* run.sh */
#!/bin/sh
# compile and run the udp_tx testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f flist.f --top-module udp_tx_tb -o udp_tx_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/udp_tx_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "all tests passed"; then
    exit 0
fi
exit 1

/* tests/udp_frame_model.svh */
`ifndef UDP_FRAME_MODEL_SVH
`define UDP_FRAME_MODEL_SVH

// expected frame, preamble through fcs
byte_t exp_q[$];
word_t lcg_state = 32'd7;

// ******************************
// random numbers
// ******************************
function automatic word_t lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
endfunction

// ones' complement fold of a 32 bit sum
function automatic half_t fold_sum(input word_t s);
    word_t t;
    t = s;
    while (t[31:16] != 16'h0000)
        t = {16'h0000, t[15:0]} + {16'h0000, t[31:16]};
    return t[15:0];
endfunction

function automatic void push_half(input half_t h);
    exp_q.push_back(h[15:8]);     // network order
    exp_q.push_back(h[7:0]);
endfunction

// ethernet crc-32 bit by bit, from exp_q[first] to the end
function automatic word_t fcs_from(input int first);
    word_t c;
    byte_t d;
    logic  fb;
    c = 32'hffff_ffff;
    for (int i = first; i < exp_q.size(); i++) begin
        d = exp_q[i];
        for (int b = 0; b < 8; b++) begin
            fb = c[0] ^ d[b];     // lsb of each byte goes first
            c  = {1'b0, c[31:1]};
            if (fb)
                c = c ^ 32'hedb8_8320;
        end
    end
    return ~c;
endfunction

// ******************************
// whole frame from its inputs
// ******************************
function automatic void build_frame(input len_t len, input mac_addr_t mac,
                                    input ip_addr_t ip, input half_t id,
                                    input word_t words[16]);
    half_t     hw[10];
    mac_addr_t dmac;
    ip_addr_t  dip;
    mac_addr_t smac;
    ip_addr_t  sip;
    word_t     s;
    word_t     fcs;
    byte_t     b;
    int        ln;
    int        n;
    ln   = int'(len);
    n    = (ln > 18) ? ln : 18;           // minimum payload
    dmac = (mac == '0) ? `DEFAULT_DST_MAC : mac;
    dip  = (ip == '0) ? `DEFAULT_DST_IP : ip;
    smac = `BOARD_MAC;
    sip  = `BOARD_IP;
    exp_q.delete();
    for (int i = 0; i < 7; i++)
        exp_q.push_back(8'h55);
    exp_q.push_back(8'hd5);
    for (int i = 2; i >= 0; i--)
        push_half(dmac[16*i +: 16]);
    for (int i = 2; i >= 0; i--)
        push_half(smac[16*i +: 16]);
    push_half(16'h0800);
    hw[0] = 16'h4500;
    hw[1] = len + 16'd28;
    hw[2] = id;
    hw[3] = 16'h4000;
    hw[4] = 16'h4011;                     // ttl 64, udp
    hw[5] = 16'h0000;
    hw[6] = sip[31:16];
    hw[7] = sip[15:0];
    hw[8] = dip[31:16];
    hw[9] = dip[15:0];
    s = '0;
    for (int i = 0; i < 10; i++)
        s = s + {16'h0000, hw[i]};
    hw[5] = ~fold_sum(s);
    for (int i = 0; i < 10; i++)
        push_half(hw[i]);
    push_half(16'd8000);
    push_half(16'd8000);
    push_half(len + 16'd8);
    push_half(16'h0000);                  // udp checksum unused
    for (int i = 0; i < n; i++) begin
        b = (i < ln) ? words[i/4][8*(3 - i%4) +: 8] : 8'h00;
        exp_q.push_back(b);
    end
    fcs = fcs_from(8);
    for (int i = 0; i < 4; i++)
        exp_q.push_back(fcs[8*i +: 8]);
endfunction

`endif

/* tests/udp_tx_tb.sv */
`timescale 1ns/1ps
`include "udp_tx_defines.svh"

module udp_tx_tb import udp_tx_pkg::*; ();

    localparam int NUM_FRAMES  = 20;
    localparam int CYCLE_LIMIT = NUM_FRAMES * 200 + 100;

    logic      clk;
    logic      rst_n;
    logic      tx_start_en;
    len_t      tx_byte_num;
    mac_addr_t des_mac;
    ip_addr_t  des_ip;
    word_t     tx_data;
    logic      tx_req;
    logic      gmii_tx_en;
    byte_t     gmii_txd;
    logic      tx_done;

    word_t pay_words[16];     // payload of the current frame
    int    req_idx;
    byte_t cap_q[$];
    int    frames_seen;
    int    done_cnt;
    int    cycles;
    int    err_data;
    int    err_ctrl;
    logic  prev_en;

    `include "udp_frame_model.svh"

    udp_tx udp_tx_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .tx_start_en (tx_start_en),
        .tx_byte_num (tx_byte_num),
        .des_mac     (des_mac),
        .des_ip      (des_ip),
        .tx_data     (tx_data),
        .tx_req      (tx_req),
        .gmii_tx_en  (gmii_tx_en),
        .gmii_txd    (gmii_txd),
        .tx_done     (tx_done)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout, run stopped after %0d cycles", cycles);
            $display("tests failed");
            $finish;
        end
    end

    // ******************************
    // capture and done check
    // ******************************
    always @(negedge clk) begin
        if (rst_n) begin
            if (gmii_tx_en)
                cap_q.push_back(gmii_txd);
            if (tx_done != (prev_en && !gmii_tx_en)) begin
                $display("ERR tx_done got %h exp %h", tx_done, prev_en && !gmii_tx_en);
                err_ctrl++;
            end
            if (prev_en && !gmii_tx_en)
                frames_seen++;
            if (tx_done)
                done_cnt++;
            prev_en = gmii_tx_en;
        end
    end

    // next word lands two cycles after the request
    always begin
        @(negedge clk);
        if (rst_n && tx_req) begin
            @(posedge clk);
            @(posedge clk);
            #1;
            if (req_idx < 16)
                tx_data = pay_words[req_idx];
            req_idx++;
        end
    end

    initial begin
        len_t      len;
        mac_addr_t mac;
        ip_addr_t  ip;
        word_t     r;
        word_t     r2;
        word_t     s;
        int        n_words;
        clk         = 1'b0;
        rst_n       = 1'b0;
        tx_start_en = 1'b0;
        tx_byte_num = '0;
        des_mac     = '0;
        des_ip      = '0;
        tx_data     = '0;
        req_idx     = 0;
        frames_seen = 0;
        done_cnt    = 0;
        cycles      = 0;
        err_data    = 0;
        err_ctrl    = 0;
        prev_en     = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        if (gmii_tx_en || tx_req || tx_done) begin
            $display("outputs not idle after reset");
            err_ctrl++;
        end

        for (int f = 0; f < NUM_FRAMES; f++) begin
            r   = lcg_next();
            len = len_t'(r[21:16]) + 16'd1;     // 1 to 64 bytes
            r   = lcg_next();
            mac = '0;
            if (r[19]) begin
                r   = lcg_next();
                r2  = lcg_next();
                mac = {r[31:16], r2};
            end
            r  = lcg_next();
            ip = r[19] ? lcg_next() : '0;
            for (int i = 0; i < 16; i++)
                pay_words[i] = lcg_next();
            n_words = (int'(len) + 3) / 4;

            @(posedge clk);
            #1;
            tx_byte_num = len;
            des_mac     = mac;
            des_ip      = ip;
            tx_data     = pay_words[0];
            req_idx     = 0;
            cap_q.delete();
            tx_start_en = 1'b1;
            repeat (3) @(posedge clk);
            #1;
            tx_start_en = 1'b0;

            // odd frames get a second start while sending
            if (f % 2 == 1) begin
                wait (gmii_tx_en);
                @(posedge clk);
                #1;
                tx_start_en = 1'b1;
                repeat (3) @(posedge clk);
                #1;
                tx_start_en = 1'b0;
            end
            wait (done_cnt > f);

            build_frame(len, mac, ip, half_t'(f + 1), pay_words);
            if (cap_q.size() != exp_q.size()) begin
                $display("frame %0d: gmii_tx_en high for %0d cycles instead of %0d",
                         f, cap_q.size(), exp_q.size());
                err_ctrl++;
            end else begin
                for (int i = 0; i < exp_q.size(); i++) begin
                    if (cap_q[i] != exp_q[i]) begin
                        $display("ERR gmii_txd frame %0d byte %0d got %h exp %h",
                                 f, i, cap_q[i], exp_q[i]);
                        err_data++;
                    end
                end
                s = '0;
                for (int i = 0; i < 10; i++)
                    s = s + {16'h0000, cap_q[22 + 2*i], cap_q[23 + 2*i]};
                if (fold_sum(s) != 16'hffff) begin
                    $display("ERR ip_header_sum frame %0d got %h exp ffff", f, fold_sum(s));
                    err_data++;
                end
            end
            if (req_idx != n_words) begin
                $display("ERR tx_req count frame %0d got %h exp %h", f, req_idx, n_words);
                err_ctrl++;
            end
            if (frames_seen != f + 1) begin
                $display("ERR frame_count got %h exp %h", frames_seen, f + 1);
                err_ctrl++;
            end
            repeat (4) @(posedge clk);
        end

        repeat (20) @(posedge clk);
        if (frames_seen != NUM_FRAMES || done_cnt != NUM_FRAMES) begin
            $display("extra frames after the last start: %0d frames, %0d done pulses",
                     frames_seen, done_cnt);
            err_ctrl++;
        end
        $display("errors: data %0d, control %0d", err_data, err_ctrl);
        if (err_data + err_ctrl == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

/* design/udp_tx.sv */
`timescale 1ns/1ps

module udp_tx import udp_tx_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      tx_start_en,
    input  len_t      tx_byte_num,
    input  mac_addr_t des_mac,
    input  ip_addr_t  des_ip,
    input  word_t     tx_data,
    output logic      tx_req,
    output logic      gmii_tx_en,
    output byte_t     gmii_txd,
    output logic      tx_done
);

    udp_hdr_t hdr;
    logic     hdr_valid;
    half_t    csum;
    logic     csum_valid;
    logic     busy;
    logic     crc_en;
    logic     crc_clr;
    byte_t    crc_din;
    word_t    crc;

    // ******************************
    // start -> checksum -> serializer
    // ******************************
    udp_start_capture start_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .tx_start_en (tx_start_en),
        .tx_byte_num (tx_byte_num),
        .des_mac     (des_mac),
        .des_ip      (des_ip),
        .busy        (busy),
        .hdr         (hdr),
        .hdr_valid   (hdr_valid)
    );

    ip_checksum csum_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .hdr        (hdr),
        .hdr_valid  (hdr_valid),
        .csum       (csum),
        .csum_valid (csum_valid)
    );

    frame_serializer ser_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .hdr        (hdr),
        .csum       (csum),
        .csum_valid (csum_valid),
        .tx_data    (tx_data),
        .crc        (crc),
        .crc_en     (crc_en),
        .crc_clr    (crc_clr),
        .crc_din    (crc_din),
        .busy       (busy),
        .tx_req     (tx_req),
        .gmii_tx_en (gmii_tx_en),
        .gmii_txd   (gmii_txd),
        .tx_done    (tx_done)
    );

    crc32_d8 crc_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .crc_clr (crc_clr),
        .crc_en  (crc_en),
        .crc_din (crc_din),
        .crc     (crc)
    );

endmodule

/* design/frame_serializer.sv */
`timescale 1ns/1ps
`include "udp_tx_defines.svh"

module frame_serializer import udp_tx_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  udp_hdr_t hdr,
    input  half_t    csum,
    input  logic     csum_valid,
    input  word_t    tx_data,
    input  word_t    crc,
    output logic     crc_en,
    output logic     crc_clr,
    output byte_t    crc_din,
    output logic     busy,
    output logic     tx_req,
    output logic     gmii_tx_en,
    output byte_t    gmii_txd,
    output logic     tx_done
);

    tx_state_e    state;
    tx_state_e    state_nxt;
    len_t         byte_cnt;      // byte index inside the current field
    logic         field_last;
    len_t         pay_total;     // payload incl. padding
    len_t         last_word;     // index of the last data word
    logic         pay_data;      // byte still inside tx_byte_num
    byte_t        pay_byte;
    word_t        fcs;
    logic [111:0] eth_vec;
    logic [223:0] ip_vec;

    assign pay_total = (hdr.payload_len > `MIN_PAYLOAD) ? hdr.payload_len : `MIN_PAYLOAD;
    assign last_word = (hdr.payload_len - 16'd1) >> 2;
    assign pay_data  = byte_cnt < hdr.payload_len;
    assign fcs       = ~crc;

    assign eth_vec = {hdr.dst_mac, `BOARD_MAC, `ETH_TYPE_IPV4};

    // ip header then udp header, udp checksum left at zero
    assign ip_vec = {`IP_VER_IHL, hdr.total_len, hdr.ip_id, `IP_FLAGS_FRAG,
                     `IP_TTL_PROTO, csum, `BOARD_IP, hdr.dst_ip,
                     `UDP_PORT, `UDP_PORT, hdr.udp_len, 16'h0000};

    // msb first within each fetched word
    always_comb begin
        case (byte_cnt[1:0])
            2'd0:    pay_byte = tx_data[31:24];
            2'd1:    pay_byte = tx_data[23:16];
            2'd2:    pay_byte = tx_data[15:8];
            default: pay_byte = tx_data[7:0];
        endcase
    end

    // ******************************
    // field sequencing
    // ******************************
    always_comb begin
        state_nxt  = state;
        field_last = 1'b0;
        case (state)
            IDLE: begin
                if (csum_valid)
                    state_nxt = PREAMBLE;
            end
            PREAMBLE: begin
                field_last = byte_cnt == 16'd7;          // 7 x 55 + sfd
                state_nxt  = ETH_HEAD;
            end
            ETH_HEAD: begin
                field_last = byte_cnt == 16'd13;
                state_nxt  = IP_HEAD;
            end
            IP_HEAD: begin
                field_last = byte_cnt == `IP_UDP_HDR_BYTES - 16'd1;
                state_nxt  = PAYLOAD;
            end
            PAYLOAD: begin
                field_last = byte_cnt == pay_total - 16'd1;
                state_nxt  = FCS;
            end
            FCS: begin
                field_last = byte_cnt == 16'd3;
                state_nxt  = IDLE;
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            byte_cnt <= '0;
            tx_done  <= 1'b0;
        end else begin
            tx_done <= (state == FCS) && field_last;
            if (state == IDLE) begin
                state    <= state_nxt;
                byte_cnt <= '0;
            end else if (field_last) begin
                state    <= state_nxt;
                byte_cnt <= '0;
            end else begin
                byte_cnt <= byte_cnt + 16'd1;
            end
        end
    end

    // ******************************
    // byte output
    // ******************************
    always_comb begin
        gmii_txd = 8'h00;
        case (state)
            PREAMBLE: gmii_txd = (byte_cnt == 16'd7) ? `SFD_BYTE : `PREAMBLE_BYTE;
            ETH_HEAD: gmii_txd = eth_vec[8*(13 - byte_cnt[3:0]) +: 8];
            IP_HEAD:  gmii_txd = ip_vec[8*(27 - byte_cnt[4:0]) +: 8];
            PAYLOAD:  gmii_txd = pay_data ? pay_byte : 8'h00;   // zero pad
            FCS:      gmii_txd = fcs[8*byte_cnt[1:0] +: 8];     // lsb first
            default:  gmii_txd = 8'h00;
        endcase
    end

    assign gmii_tx_en = state != IDLE;
    assign busy       = state != IDLE;

    // word fetch two bytes ahead, none inside the last data word
    always_comb begin
        tx_req = 1'b0;
        if (state == IP_HEAD)
            tx_req = byte_cnt == `IP_UDP_HDR_BYTES - 16'd2;
        else if (state == PAYLOAD)
            tx_req = (byte_cnt[1:0] == 2'd2) && ({2'b00, byte_cnt[15:2]} < last_word);
    end

    // crc runs from dst mac through the last pad byte
    assign crc_en  = (state == ETH_HEAD) || (state == IP_HEAD) || (state == PAYLOAD);
    assign crc_clr = (state == PREAMBLE) && field_last;
    assign crc_din = gmii_txd;

    a_req_in_frame: assert property (
        @(posedge clk) disable iff (!rst_n) tx_req |-> gmii_tx_en
    );

    a_frame_no_gap: assert property (
        @(posedge clk) disable iff (!rst_n)
        (gmii_tx_en && !(state == FCS && field_last)) |=> gmii_tx_en
    );

endmodule

/* design/crc32_d8.sv */
`timescale 1ns/1ps

module crc32_d8 import udp_tx_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  crc_clr,
    input  logic  crc_en,
    input  byte_t crc_din,
    output word_t crc
);

    // ******************************
    // reflected crc-32, lsb first
    // ******************************
    function automatic word_t crc_byte(input word_t c, input byte_t d);
        word_t r;
        r = c ^ word_t'(d);
        for (int i = 0; i < 8; i++) begin
            if (r[0])
                r = (r >> 1) ^ 32'hedb8_8320;
            else
                r = r >> 1;
        end
        return r;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            crc <= '1;
        else if (crc_clr)
            crc <= '1;                     // seed for next frame
        else if (crc_en)
            crc <= crc_byte(crc, crc_din);
    end

endmodule

/* design/ip_checksum.sv */
`timescale 1ns/1ps
`include "udp_tx_defines.svh"

module ip_checksum import udp_tx_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  udp_hdr_t hdr,
    input  logic     hdr_valid,
    output half_t    csum,
    output logic     csum_valid
);

    logic [159:0] ip_words;   // ten halfwords, checksum field zero
    word_t        sum_c;
    word_t        acc;
    logic         sum_v;
    logic         fold1_v;
    logic         fold2_v;

    assign ip_words = {`IP_VER_IHL, hdr.total_len, hdr.ip_id, `IP_FLAGS_FRAG,
                       `IP_TTL_PROTO, 16'h0000, `BOARD_IP, hdr.dst_ip};

    always_comb begin
        sum_c = '0;
        for (int i = 0; i < 10; i++)
            sum_c = sum_c + word_t'(ip_words[16*i +: 16]);
    end

    // ******************************
    // sum, fold, fold, invert
    // ******************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sum_v      <= 1'b0;
            fold1_v    <= 1'b0;
            fold2_v    <= 1'b0;
            csum_valid <= 1'b0;
        end else begin
            sum_v      <= hdr_valid;
            fold1_v    <= sum_v;
            fold2_v    <= fold1_v;
            csum_valid <= fold2_v;
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_valid)
            acc <= sum_c;
        else if (sum_v || fold1_v)
            acc <= word_t'(acc[31:16]) + word_t'(acc[15:0]);   // end-around carry
        if (fold2_v)
            csum <= ~acc[15:0];
    end

    a_csum_latency: assert property (
        @(posedge clk) disable iff (!rst_n) hdr_valid |-> ##4 csum_valid
    );

    // two folds leave no carry for a ten halfword sum
    a_fold_done: assert property (
        @(posedge clk) disable iff (!rst_n) fold2_v |-> acc[31:16] == 16'h0000
    );

endmodule

/* design/udp_start_capture.sv */
`timescale 1ns/1ps
`include "udp_tx_defines.svh"

module udp_start_capture import udp_tx_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      tx_start_en,
    input  len_t      tx_byte_num,
    input  mac_addr_t des_mac,
    input  ip_addr_t  des_ip,
    input  logic      busy,
    output udp_hdr_t  hdr,
    output logic      hdr_valid
);

    logic  start_d0;
    logic  start_d1;
    logic  start_edge;
    logic  accept;         // edge taken, header loads next cycle
    logic  pending;        // frame between accept and serializer busy
    half_t id_cnt;

    // two flop sampling of the start level
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_d0 <= 1'b0;
            start_d1 <= 1'b0;
        end else begin
            start_d0 <= tx_start_en;
            start_d1 <= start_d0;
        end
    end

    assign start_edge = start_d0 & ~start_d1;

    // edges during a frame are dropped here
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            accept    <= 1'b0;
            pending   <= 1'b0;
            hdr_valid <= 1'b0;
            id_cnt    <= '0;
        end else begin
            accept    <= start_edge & ~busy & ~pending;
            hdr_valid <= accept;
            if (start_edge && !busy && !pending)
                pending <= 1'b1;
            else if (busy)
                pending <= 1'b0;       // serializer owns the frame now
            if (accept)
                id_cnt <= id_cnt + 16'd1;
        end
    end

    // header fields all change with the hdr_valid pulse
    always_ff @(posedge clk) begin
        if (accept) begin
            hdr.ip_id       <= id_cnt + 16'd1;
            hdr.payload_len <= tx_byte_num;
            hdr.total_len   <= tx_byte_num + `IP_UDP_HDR_BYTES;
            hdr.udp_len     <= tx_byte_num + `UDP_HDR_BYTES;
            hdr.dst_ip      <= (des_ip != '0) ? des_ip : `DEFAULT_DST_IP;
            hdr.dst_mac     <= (des_mac != '0) ? des_mac : `DEFAULT_DST_MAC;
        end
    end

    // one frame in flight at most, so no new header while sending
    a_no_hdr_when_busy: assert property (
        @(posedge clk) disable iff (!rst_n) hdr_valid |-> !busy
    );

endmodule

/* design/udp_tx_pkg.sv */
package udp_tx_pkg;

    // ******************************
    // basic vectors
    // ******************************
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] half_t;
    typedef logic [31:0] word_t;
    typedef logic [15:0] len_t;       // byte count
    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ip_addr_t;

    // per frame header info, captured at start
    typedef struct packed {
        half_t     ip_id;
        len_t      total_len;         // ip total length
        len_t      udp_len;
        len_t      payload_len;
        ip_addr_t  dst_ip;
        mac_addr_t dst_mac;
    } udp_hdr_t;

    // serializer fields in wire order
    typedef enum logic [2:0] {
        IDLE,
        PREAMBLE,
        ETH_HEAD,
        IP_HEAD,
        PAYLOAD,
        FCS
    } tx_state_e;

endpackage

/* design/udp_tx_defines.svh */
`ifndef UDP_TX_DEFINES_SVH
`define UDP_TX_DEFINES_SVH

// ******************************
// board addresses
// ******************************
`define BOARD_MAC         48'h00_11_22_33_44_55
`define BOARD_IP          {8'd192, 8'd168, 8'd1, 8'd123}

// used when the des_mac / des_ip ports are zero
`define DEFAULT_DST_MAC   48'hff_ff_ff_ff_ff_ff
`define DEFAULT_DST_IP    {8'd192, 8'd168, 8'd1, 8'd102}

// ******************************
// protocol fields
// ******************************
`define ETH_TYPE_IPV4     16'h0800
`define UDP_PORT          16'd8000        // source and destination
`define IP_VER_IHL        16'h4500        // version 4, 5 words, tos 0
`define IP_FLAGS_FRAG     16'h4000        // don't fragment
`define IP_TTL_PROTO      16'h4011        // ttl 64, protocol udp

// byte counts
`define MIN_PAYLOAD       16'd18          // 46 byte ip minimum less 28
`define IP_UDP_HDR_BYTES  16'd28
`define UDP_HDR_BYTES     16'd8

`define PREAMBLE_BYTE     8'h55
`define SFD_BYTE          8'hd5

`endif
